//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// RAM depth in 32-bit words
`define MEM_WORDS 512

// APB word address map
`define APB_ADDR_W 10
`define REG_CTRL 10'h200
`define REG_OUT 10'h201

// Longest instruction ends on this step
`define MAX_STEP 7

`endif

//--- common/cpuTypesPkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpuTypesPkg;

	typedef logic [31:0] word;
	typedef logic [3:0] regIndex;
	typedef logic [$clog2(`MEM_WORDS)-1:0] memAddr;

	// Taken from IR[31:27]
	// opBr covers brzr and brnz, the condition sits in IR[20:19]
	typedef enum logic [4:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opShr = 5'd7,
		opShl = 5'd8,
		opNeg = 5'd9,
		opNot = 5'd10,
		opAddi = 5'd11,
		opAndi = 5'd12,
		opOri = 5'd13,
		opBr = 5'd14,
		opIn = 5'd15,
		opOut = 5'd16,
		opNop = 5'd17,
		opHalt = 5'd18
	} opcodeT;

endpackage

`default_nettype wire

//--- common/controlPkg.sv
`default_nettype none

`include "cpu_config.svh"

package controlPkg;

	typedef enum logic [1:0] {
		phaseIdle,
		phaseFetch,
		phaseExecute,
		phaseHalted
	} phaseT;

	typedef logic [$clog2(`MAX_STEP + 1)-1:0] stepT;

	// IR is valid from the step after this one
	localparam stepT lastFetchStep = 3'd2;

endpackage

`default_nettype wire

//--- common/cpuIfs.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;
	import cpuTypesPkg::*;

	logic pcIn, irIn, marIn, mdrIn;
	logic yIn, zIn, outIn, conIn;
	logic pcOut, zOut, mdrOut, inOut, cOut;
	logic gra, grb, grc;
	logic rIn, rOut, baOut;
	logic incPc;
	logic memRead, memWrite;
	word ir;
	logic conFlag;

	modport ctl (
		output pcIn, irIn, marIn, mdrIn, yIn, zIn, outIn, conIn,
		output pcOut, zOut, mdrOut, inOut, cOut,
		output gra, grb, grc, rIn, rOut, baOut, incPc, memRead, memWrite,
		input ir, conFlag
	);

	modport dp (
		input pcIn, irIn, marIn, mdrIn, yIn, zIn, outIn, conIn,
		input pcOut, zOut, mdrOut, inOut, cOut,
		input gra, grb, grc, rIn, rOut, baOut, incPc, memRead, memWrite,
		output ir, conFlag
	);
endinterface

interface memIf;
	import cpuTypesPkg::*;

	memAddr addr;
	word wData;
	logic read;
	logic write;
	word rData;
	logic busy;

	modport cpu (output addr, wData, read, write, input rData, busy);
	modport mem (input addr, wData, read, write, output rData, busy);
endinterface

`default_nettype wire

//--- datapath/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic arstN,
	input logic [15:0] writeEnable,
	input logic [15:0] readEnable,
	input logic baOut,
	input cpuTypesPkg::word busIn,
	output cpuTypesPkg::word readData
);
	import cpuTypesPkg::*;

	word regs [16];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 16; i++) begin
				if (writeEnable[i]) begin
					regs[i] <= busIn;
				end
			end
		end
	end

	// R0 reads as zero when it is a base address
	always_comb begin
		readData = '0;
		for (int i = 0; i < 16; i++) begin
			if (readEnable[i] && !(i == 0 && baOut)) begin
				readData = readData | regs[i];
			end
		end
	end

	enableCheck: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0(writeEnable) && $onehot0(readEnable));

endmodule

`default_nettype wire

//--- datapath/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
	input cpuTypesPkg::opcodeT opcode,
	input logic incPc,
	input cpuTypesPkg::word a,
	input cpuTypesPkg::word b,
	output cpuTypesPkg::word result
);
	import cpuTypesPkg::*;

	always_comb begin
		if (incPc) begin
			result = b + word'(1);
		end else begin
			case (opcode)
				// Address sums use the same adder
				opAdd, opAddi, opLd, opLdi, opSt, opBr: begin
					result = a + b;
				end
				opSub: begin
					result = a - b;
				end
				opAnd, opAndi: begin
					result = a & b;
				end
				opOr, opOri: begin
					result = a | b;
				end
				opShr: begin
					result = a >> b[4:0];
				end
				opShl: begin
					result = a << b[4:0];
				end
				// Unary ops take Y
				opNeg: begin
					result = -a;
				end
				opNot: begin
					result = ~a;
				end
				default: begin
					result = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- datapath/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath (
	input logic clk,
	input logic arstN,
	ctrlIf.dp dp,
	memIf.cpu mem,
	input cpuTypesPkg::word inPort,
	output cpuTypesPkg::word outPort
);
	import cpuTypesPkg::*;

	word bus, pc, ir, mdr, y, z;
	word inReg, cSext, regData, aluResult;
	memAddr mar;
	regIndex field;
	logic [15:0] regSelect;
	logic [2:0] busSel;
	logic conBit, conFlag;

	assign dp.ir = ir;
	assign dp.conFlag = conFlag;
	assign mem.addr = mar;
	assign mem.wData = mdr;
	assign mem.read = dp.memRead;
	assign mem.write = dp.memWrite;
	assign cSext = {{13{ir[18]}}, ir[18:0]};

	// Ra, Rb or Rc out of the IR
	always_comb begin
		if (dp.gra) begin
			field = ir[26:23];
		end else if (dp.grb) begin
			field = ir[22:19];
		end else if (dp.grc) begin
			field = ir[18:15];
		end else begin
			field = '0;
		end
	end
	assign regSelect = 16'b1 << field;

	registerFile regFile (
		.clk,
		.arstN,
		.writeEnable({16{dp.rIn}} & regSelect),
		.readEnable({16{dp.rOut}} & regSelect),
		.baOut(dp.baOut),
		.busIn(bus),
		.readData(regData)
	);

	aluUnit alu (
		.opcode(opcodeT'(ir[31:27])),
		.incPc(dp.incPc),
		.a(y),
		.b(bus),
		.result(aluResult)
	);

	// Bus encoder, then the mux
	always_comb begin
		if (dp.rOut) begin
			busSel = 3'd1;
		end else if (dp.pcOut) begin
			busSel = 3'd2;
		end else if (dp.zOut) begin
			busSel = 3'd3;
		end else if (dp.mdrOut) begin
			busSel = 3'd4;
		end else if (dp.inOut) begin
			busSel = 3'd5;
		end else if (dp.cOut) begin
			busSel = 3'd6;
		end else begin
			busSel = 3'd0;
		end
	end

	always_comb begin
		case (busSel)
			3'd1: bus = regData;
			3'd2: bus = pc;
			3'd3: bus = z;
			3'd4: bus = mdr;
			3'd5: bus = inReg;
			3'd6: bus = cSext;
			default: bus = '0;
		endcase
	end

	// Branch condition on the Ra value
	always_comb begin
		case (ir[20:19])
			2'd0: conBit = bus == '0;
			2'd1: conBit = bus != '0;
			default: conBit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			ir <= '0;
			mar <= '0;
			mdr <= '0;
			y <= '0;
			z <= '0;
			inReg <= '0;
			outPort <= '0;
			conFlag <= 1'b0;
		end else begin
			inReg <= inPort;
			if (dp.pcIn) begin
				pc <= dp.incPc ? aluResult : bus;
			end
			if (dp.irIn) begin
				ir <= bus;
			end
			if (dp.marIn) begin
				mar <= memAddr'(bus);
			end
			if (dp.mdrIn) begin
				mdr <= dp.memRead ? mem.rData : bus;
			end
			if (dp.yIn) begin
				y <= bus;
			end
			if (dp.zIn) begin
				z <= aluResult;
			end
			if (dp.outIn) begin
				outPort <= bus;
			end
			if (dp.conIn) begin
				conFlag <= conBit;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/stepCounter.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module stepCounter (
	input logic clk,
	input logic arstN,
	input logic clear,
	input logic hold,
	output controlPkg::stepT step
);
	import controlPkg::*;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			step <= '0;
		end else if (clear) begin
			step <= '0;
		end else if (!hold) begin
			step <= step + stepT'(1);
		end
	end

	// Count must not wrap past the last step
	maxStepCheck: assert property (@(posedge clk) disable iff (!arstN)
		(step == stepT'(`MAX_STEP)) && !hold |-> clear);

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic busy,
	input controlPkg::stepT step,
	ctrlIf.ctl ctl,
	output logic stepClear,
	output logic running,
	output logic halted
);
	import cpuTypesPkg::*;
	import controlPkg::*;

	phaseT phase;
	opcodeT opcode;
	logic lastStep;
	logic isMemOp, isRegOp, isAluForm;

	assign opcode = opcodeT'(ctl.ir[31:27]);
	assign isMemOp = opcode inside {opLd, opSt};
	assign isRegOp = opcode inside {opAdd, opSub, opAnd, opOr, opShr, opShl, opNeg, opNot};
	assign isAluForm = isMemOp || isRegOp || (opcode inside {opLdi, opAddi, opAndi, opOri});
	assign running = (phase == phaseFetch) || (phase == phaseExecute);
	assign halted = phase == phaseHalted;
	assign stepClear = !running || (lastStep && !busy);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			phase <= phaseIdle;
		end else begin
			case (phase)
				phaseIdle, phaseHalted: begin
					if (start) begin
						phase <= phaseFetch;
					end
				end
				phaseFetch: begin
					if (step == lastFetchStep) begin
						phase <= phaseExecute;
					end
				end
				phaseExecute: begin
					if (opcode == opHalt) begin
						phase <= phaseHalted;
					end else if (stepClear) begin
						phase <= phaseFetch;
					end
				end
				default: begin
					phase <= phaseIdle;
				end
			endcase
		end
	end

	always_comb begin
		{ctl.pcIn, ctl.irIn, ctl.marIn, ctl.mdrIn} = '0;
		{ctl.yIn, ctl.zIn, ctl.outIn, ctl.conIn} = '0;
		{ctl.pcOut, ctl.zOut, ctl.mdrOut, ctl.inOut, ctl.cOut} = '0;
		{ctl.gra, ctl.grb, ctl.grc, ctl.rIn, ctl.rOut, ctl.baOut} = '0;
		{ctl.incPc, ctl.memRead, ctl.memWrite} = '0;
		lastStep = 1'b0;
		case (phase)
			// Empty bus on start loads PC with 0
			phaseIdle, phaseHalted: begin
				ctl.pcIn = start;
			end
			phaseFetch: begin
				case (step)
					3'd0: begin
						{ctl.pcOut, ctl.marIn, ctl.incPc, ctl.zIn, ctl.pcIn} = '1;
					end
					// Y keeps the new PC for branch targets
					3'd1: begin
						{ctl.memRead, ctl.mdrIn, ctl.pcOut, ctl.yIn} = '1;
					end
					default: begin
						{ctl.mdrOut, ctl.irIn} = '1;
					end
				endcase
			end
			phaseExecute: begin
				if (isAluForm) begin
					case (step)
						3'd3: begin
							{ctl.grb, ctl.rOut, ctl.yIn} = '1;
							ctl.baOut = isMemOp || (opcode == opLdi);
						end
						3'd4: begin
							ctl.zIn = 1'b1;
							ctl.grc = isRegOp;
							ctl.rOut = isRegOp;
							ctl.cOut = !isRegOp;
						end
						3'd5: begin
							ctl.zOut = 1'b1;
							ctl.marIn = isMemOp;
							ctl.gra = !isMemOp;
							ctl.rIn = !isMemOp;
							lastStep = !isMemOp;
						end
						3'd6: begin
							ctl.mdrIn = 1'b1;
							ctl.memRead = opcode == opLd;
							ctl.gra = opcode == opSt;
							ctl.rOut = opcode == opSt;
						end
						3'd7: begin
							ctl.mdrOut = opcode == opLd;
							ctl.gra = opcode == opLd;
							ctl.rIn = opcode == opLd;
							ctl.memWrite = opcode == opSt;
							lastStep = 1'b1;
						end
						default: begin
							lastStep = 1'b0;
						end
					endcase
				end else if (opcode == opBr) begin
					case (step)
						3'd3: begin
							{ctl.gra, ctl.rOut, ctl.conIn} = '1;
						end
						3'd4: begin
							{ctl.cOut, ctl.zIn} = '1;
						end
						default: begin
							ctl.zOut = 1'b1;
							ctl.pcIn = ctl.conFlag;
							lastStep = 1'b1;
						end
					endcase
				end else begin
					ctl.inOut = opcode == opIn;
					ctl.gra = opcode inside {opIn, opOut};
					ctl.rIn = opcode == opIn;
					ctl.rOut = opcode == opOut;
					ctl.outIn = opcode == opOut;
					lastStep = 1'b1;
				end
			end
			default: begin
				lastStep = 1'b0;
			end
		endcase
	end

	busDriverCheck: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({ctl.pcOut, ctl.zOut, ctl.mdrOut, ctl.inOut, ctl.cOut, ctl.rOut}));

endmodule

`default_nettype wire

//--- source/memoryApb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module memoryApb (
	input logic clk,
	input logic arstN,
	memIf.mem mem,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [`APB_ADDR_W-1:0] pAddr,
	input cpuTypesPkg::word pWData,
	output cpuTypesPkg::word pRData,
	output logic pReady,
	input cpuTypesPkg::word outPort,
	input logic running,
	input logic halted,
	output logic start
);
	import cpuTypesPkg::*;

	word ram [`MEM_WORDS];
	word ramQ;
	logic cpuDone, apbDone;
	logic cpuOp, apbAccess, apbRam, apbOp;

	// One RAM cycle per access, completion the cycle after
	assign cpuOp = (mem.read || mem.write) && !cpuDone;
	assign apbAccess = pSel && pEnable;
	assign apbRam = apbAccess && (pAddr < `MEM_WORDS);
	assign apbOp = apbRam && !apbDone && !cpuOp;
	assign mem.busy = cpuOp;
	assign mem.rData = ramQ;
	assign pReady = !apbRam || apbDone;
	assign start = apbAccess && pWrite && (pAddr == `REG_CTRL) && pWData[0];

	always_comb begin
		if (apbRam) begin
			pRData = ramQ;
		end else if (pAddr == `REG_CTRL) begin
			pRData = {30'd0, halted, running};
		end else if (pAddr == `REG_OUT) begin
			pRData = outPort;
		end else begin
			pRData = '0;
		end
	end

	// Single port, CPU first
	always_ff @(posedge clk) begin
		if (cpuOp) begin
			if (mem.write) begin
				ram[mem.addr] <= mem.wData;
			end else begin
				ramQ <= ram[mem.addr];
			end
		end else if (apbOp) begin
			if (pWrite) begin
				ram[memAddr'(pAddr)] <= pWData;
			end else begin
				ramQ <= ram[memAddr'(pAddr)];
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cpuDone <= 1'b0;
			apbDone <= 1'b0;
		end else begin
			cpuDone <= cpuOp;
			apbDone <= apbOp;
		end
	end

	apbSetupCheck: assert property (@(posedge clk) disable iff (!arstN)
		$rose(pSel) |-> !pEnable ##1 pEnable);

endmodule

`default_nettype wire

//--- source/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module cpuTop (
	input logic clk,
	input logic arstN,
	input cpuTypesPkg::word inPort,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [`APB_ADDR_W-1:0] pAddr,
	input cpuTypesPkg::word pWData,
	output cpuTypesPkg::word pRData,
	output logic pReady,
	output cpuTypesPkg::word outPort
);
	import controlPkg::*;

	stepT step;
	logic stepClear;
	logic start;
	logic running;
	logic halted;

	ctrlIf ctrlBus ();
	memIf memBus ();

	controlUnit ctrl (
		.clk,
		.arstN,
		.start,
		.busy(memBus.busy),
		.step,
		.ctl(ctrlBus.ctl),
		.stepClear,
		.running,
		.halted
	);

	// Step holds while the RAM is busy
	stepCounter steps (
		.clk,
		.arstN,
		.clear(stepClear),
		.hold(memBus.busy),
		.step
	);

	datapath dpath (
		.clk,
		.arstN,
		.dp(ctrlBus.dp),
		.mem(memBus.cpu),
		.inPort,
		.outPort
	);

	memoryApb memory (
		.clk,
		.arstN,
		.mem(memBus.mem),
		.pSel,
		.pEnable,
		.pWrite,
		.pAddr,
		.pWData,
		.pRData,
		.pReady,
		.outPort,
		.running,
		.halted,
		.start
	);

endmodule

`default_nettype wire

//--- bench/cpuTopTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_config.svh"

module cpuTopTb;
	import cpuTypesPkg::*;

	localparam int clockPeriod = 4;
	localparam int pollLimit = 500;
	// Executed instructions and APB transfers per test without polling
	localparam int testSteps = 0 + 37 + 14 + 38 + 4 + 52;
	localparam int testTransfers = 34 + 50 + 21 + 16 + 6 + 19;
	localparam int watchdogCycles = 2 * (testSteps * 7 + testTransfers * 4);

	logic clk;
	logic arstN;
	word inPort;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [`APB_ADDR_W-1:0] pAddr;
	word pWData;
	word pRData;
	logic pReady;
	word outPort;

	integer seed;
	int errors;
	int checks;
	word prog[$];
	word modelMem [`MEM_WORDS];
	word modelRegs [16];
	word modelOut;

	cpuTop dut (
		.clk,
		.arstN,
		.inPort,
		.pSel,
		.pEnable,
		.pWrite,
		.pAddr,
		.pWData,
		.pRData,
		.pReady,
		.outPort
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clockPeriod / 2) clk = ~clk;
		end
	end

	function automatic word encReg(input opcodeT op, input regIndex ra, input regIndex rb,
			input regIndex rc);
		return {op, ra, rb, rc, 15'd0};
	endfunction

	function automatic word encImm(input opcodeT op, input regIndex ra, input regIndex rb,
			input int c);
		return {op, ra, rb, c[18:0]};
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic checkValue(input string name, input word got, input word expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Check failed, %s", what);
		end
	endtask

	// Setup cycle, then access until pReady
	task automatic apbTransfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
			input word wData, output word rData);
		nextCycle();
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWData = wData;
		nextCycle();
		pEnable = 1'b1;
		#2;
		while (!pReady) begin
			@(posedge clk);
			#3;
		end
		rData = pRData;
		nextCycle();
		pSel = 1'b0;
		pEnable = 1'b0;
	endtask

	task automatic apbWrite(input logic [`APB_ADDR_W-1:0] addr, input word data);
		word unused;
		apbTransfer(1'b1, addr, data, unused);
	endtask

	task automatic apbRead(input logic [`APB_ADDR_W-1:0] addr, output word data);
		apbTransfer(1'b0, addr, '0, data);
	endtask

	task automatic writeMem(input memAddr addr, input word data);
		apbWrite({1'b0, addr}, data);
		modelMem[addr] = data;
	endtask

	task automatic checkMem(input memAddr addr);
		word got;
		apbRead({1'b0, addr}, got);
		checkValue($sformatf("mem[%h]", addr), got, modelMem[addr]);
	endtask

	task automatic checkOut();
		word got;
		apbRead(`REG_OUT, got);
		checkValue("REG_OUT", got, modelOut);
		checkValue("outPort", outPort, modelOut);
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			writeMem(memAddr'(i), prog[i]);
		end
	endtask

	// Instruction level model of the ISA
	task automatic modelRun();
		word ir;
		word c;
		word rav;
		word rbv;
		word rcv;
		word base;
		memAddr pc;
		regIndex ra;
		logic done;
		int count;
		pc = '0;
		done = 1'b0;
		count = 0;
		while (!done && count < 1000) begin
			ir = modelMem[pc];
			pc = pc + memAddr'(1);
			count++;
			ra = ir[26:23];
			rav = modelRegs[ra];
			rbv = modelRegs[ir[22:19]];
			rcv = modelRegs[ir[18:15]];
			c = word'($signed(ir[18:0]));
			// R0 as base means absolute
			base = (ir[22:19] == 4'd0) ? '0 : rbv;
			case (opcodeT'(ir[31:27]))
				opLd: modelRegs[ra] = modelMem[memAddr'(base + c)];
				opLdi: modelRegs[ra] = base + c;
				opSt: modelMem[memAddr'(base + c)] = rav;
				opAdd: modelRegs[ra] = rbv + rcv;
				opSub: modelRegs[ra] = rbv - rcv;
				opAnd: modelRegs[ra] = rbv & rcv;
				opOr: modelRegs[ra] = rbv | rcv;
				opShr: modelRegs[ra] = rbv >> rcv[4:0];
				opShl: modelRegs[ra] = rbv << rcv[4:0];
				opNeg: modelRegs[ra] = -rbv;
				opNot: modelRegs[ra] = ~rbv;
				opAddi: modelRegs[ra] = rbv + c;
				opAndi: modelRegs[ra] = rbv & c;
				opOri: modelRegs[ra] = rbv | c;
				opBr: begin
					if ((ir[20:19] == 2'd0 && rav == '0) || (ir[20:19] == 2'd1 && rav != '0)) begin
						pc = memAddr'(word'(pc) + c);
					end
				end
				opIn: modelRegs[ra] = inPort;
				opOut: modelOut = rav;
				opHalt: done = 1'b1;
				default: begin
				end
			endcase
		end
	endtask

	task automatic runProgram(output logic sawRunning);
		word status;
		int polls;
		sawRunning = 1'b0;
		polls = 0;
		apbWrite(`REG_CTRL, 32'h1);
		do begin
			apbRead(`REG_CTRL, status);
			if (status[0]) begin
				sawRunning = 1'b1;
			end
			polls++;
		end while (!status[1] && polls < pollLimit);
		checkTrue(status[1], "processor did not halt within the poll limit");
		modelRun();
	endtask

	task automatic emitResult(input word instr, input memAddr slot);
		prog.push_back(instr);
		prog.push_back(encImm(opOut, instr[26:23], 4'd0, 0));
		prog.push_back(encImm(opSt, instr[26:23], 4'd0, int'(slot)));
	endtask

	task automatic buildLoop(input int count);
		prog.delete();
		prog.push_back(encImm(opLdi, 4'd1, 4'd0, count));
		prog.push_back(encImm(opLdi, 4'd2, 4'd0, 0));
		prog.push_back(encImm(opLdi, 4'd5, 4'd0, 0));
		// Loop body starts at word 3
		prog.push_back(encImm(opAddi, 4'd2, 4'd2, 1));
		prog.push_back(encImm(opAddi, 4'd1, 4'd1, -1));
		prog.push_back(encImm(opBr, 4'd1, 4'd1, -3));
		prog.push_back(encImm(opBr, 4'd1, 4'd0, 1));
		// Only reached if the exit branch fails
		prog.push_back(encImm(opLdi, 4'd5, 4'd0, 1));
		prog.push_back(encImm(opSt, 4'd2, 4'd0, 'h180));
		prog.push_back(encImm(opSt, 4'd5, 4'd0, 'h181));
		prog.push_back(encImm(opOut, 4'd2, 4'd0, 0));
		prog.push_back(encImm(opHalt, 4'd0, 4'd0, 0));
	endtask

	task automatic resetTest();
		word got;
		memAddr addrs[$];
		apbRead(`REG_CTRL, got);
		checkValue("REG_CTRL", got, '0);
		apbRead(`REG_OUT, got);
		checkValue("REG_OUT", got, '0);
		for (int i = 0; i < 16; i++) begin
			addrs.push_back(memAddr'($random(seed)));
			writeMem(addrs[i], $random(seed));
		end
		foreach (addrs[i]) begin
			checkMem(addrs[i]);
		end
	endtask

	task automatic aluTest();
		int imm;
		logic sawRunning;
		prog.delete();
		prog.push_back(encImm(opLdi, 4'd1, 4'd0, $random(seed)));
		prog.push_back(encImm(opLdi, 4'd2, 4'd0, $random(seed)));
		prog.push_back(encImm(opLdi, 4'd3, 4'd0, $random(seed) & 31));
		imm = $random(seed);
		emitResult(encReg(opAdd, 4'd4, 4'd1, 4'd2), 9'h100);
		emitResult(encReg(opSub, 4'd5, 4'd1, 4'd2), 9'h101);
		emitResult(encReg(opAnd, 4'd6, 4'd1, 4'd2), 9'h102);
		emitResult(encReg(opOr, 4'd7, 4'd1, 4'd2), 9'h103);
		emitResult(encReg(opShl, 4'd8, 4'd1, 4'd3), 9'h104);
		emitResult(encReg(opShr, 4'd9, 4'd1, 4'd3), 9'h105);
		emitResult(encReg(opNeg, 4'd10, 4'd1, 4'd0), 9'h106);
		emitResult(encReg(opNot, 4'd11, 4'd1, 4'd0), 9'h107);
		emitResult(encImm(opAddi, 4'd12, 4'd1, imm), 9'h108);
		emitResult(encImm(opAndi, 4'd13, 4'd2, imm), 9'h109);
		emitResult(encImm(opOri, 4'd14, 4'd2, imm), 9'h10A);
		prog.push_back(encImm(opHalt, 4'd0, 4'd0, 0));
		loadProgram();
		runProgram(sawRunning);
		checkOut();
		for (int i = 0; i < 11; i++) begin
			checkMem(9'h100 + memAddr'(i));
		end
	endtask

	task automatic memoryTest();
		memAddr base;
		logic sawRunning;
		base = 9'h150 + memAddr'($random(seed) & 15);
		prog.delete();
		// Nonzero R0 so an absolute address differs from R0 plus C
		prog.push_back(encImm(opLdi, 4'd0, 4'd0, 'h2A));
		prog.push_back(encImm(opLdi, 4'd1, 4'd0, int'(base)));
		prog.push_back(encImm(opLdi, 4'd2, 4'd0, $random(seed)));
		prog.push_back(encImm(opLdi, 4'd3, 4'd0, $random(seed)));
		prog.push_back(encImm(opSt, 4'd2, 4'd1, 5));
		prog.push_back(encImm(opSt, 4'd3, 4'd0, 'h1C0));
		prog.push_back(encImm(opLd, 4'd4, 4'd1, 5));
		prog.push_back(encImm(opLd, 4'd5, 4'd0, 'h1C0));
		prog.push_back(encReg(opAdd, 4'd6, 4'd4, 4'd5));
		prog.push_back(encImm(opSt, 4'd6, 4'd1, -3));
		prog.push_back(encImm(opSt, 4'd4, 4'd0, 'h1C1));
		prog.push_back(encImm(opSt, 4'd5, 4'd0, 'h1C2));
		prog.push_back(encImm(opOut, 4'd6, 4'd0, 0));
		prog.push_back(encImm(opHalt, 4'd0, 4'd0, 0));
		loadProgram();
		runProgram(sawRunning);
		checkMem(base + memAddr'(5));
		checkMem(base - memAddr'(3));
		checkMem(9'h1C0);
		checkMem(9'h1C1);
		checkMem(9'h1C2);
		checkOut();
	endtask

	task automatic loopTest();
		int count;
		word got;
		logic sawRunning;
		count = 3 + ($random(seed) & 7);
		buildLoop(count);
		loadProgram();
		runProgram(sawRunning);
		checkOut();
		checkValue("loop count", outPort, word'(count));
		checkMem(9'h180);
		apbRead(10'h181, got);
		checkValue("mem[181]", got, '0);
	endtask

	task automatic portTest();
		logic [18:0] imm;
		word got;
		logic sawRunning;
		inPort = $random(seed);
		imm = $random(seed);
		prog.delete();
		prog.push_back(encImm(opIn, 4'd1, 4'd0, 0));
		prog.push_back(encImm(opAddi, 4'd2, 4'd1, int'(imm)));
		prog.push_back(encImm(opOut, 4'd2, 4'd0, 0));
		prog.push_back(encImm(opHalt, 4'd0, 4'd0, 0));
		loadProgram();
		runProgram(sawRunning);
		apbRead(`REG_OUT, got);
		checkValue("REG_OUT", got, inPort + word'($signed(imm)));
	endtask

	task automatic rerunTest();
		logic sawRunning;
		buildLoop(6);
		loadProgram();
		runProgram(sawRunning);
		checkTrue(sawRunning, "running status never seen during the first run");
		checkOut();
		checkMem(9'h180);
		// Cleared so only a second run restores the count
		writeMem(9'h180, '0);
		runProgram(sawRunning);
		checkTrue(sawRunning, "running status never seen during the second run");
		checkOut();
		checkMem(9'h180);
	endtask

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Timeout after %0d cycles, the tests did not finish", watchdogCycles);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed = 90706;
		errors = 0;
		checks = 0;
		arstN = 1'b0;
		inPort = '0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		modelOut = '0;
		foreach (modelMem[i]) begin
			modelMem[i] = '0;
		end
		foreach (modelRegs[i]) begin
			modelRegs[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;
		resetTest();
		aluTest();
		memoryTest();
		loopTest();
		portTest();
		rerunTest();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpuTop.f
+incdir+common
common/cpuTypesPkg.sv
common/controlPkg.sv
common/cpuIfs.sv
datapath/registerFile.sv
datapath/aluUnit.sv
datapath/datapath.sv
source/stepCounter.sv
source/controlUnit.sv
source/memoryApb.sv
source/cpuTop.sv
bench/cpuTopTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTopTb
FILELIST ?= cpuTop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q '^NO ERRORS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
